//--- logic/fetch_pkg.sv
// ************************************************
// Fetch package
// Sizes, OBI structs and instruction word views
// ************************************************

package fetch_pkg;

  // Prefetch entries and the cap on outstanding plus buffered fetches
  localparam int FIFO_DEPTH = 2;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int SLOT_W     = $clog2(FIFO_DEPTH + 1);
  localparam int CNT_W      = 16;

  typedef logic [PTR_W-1:0]  ptr_t;
  typedef logic [SLOT_W-1:0] slot_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  localparam slot_t SLOT_MAX = slot_t'(FIFO_DEPTH);

  // RV32I major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } fetch_entry_t;

  // One instruction word seen as R-type or as I-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_u;

endpackage

//--- logic/fetch_prefetch_ctrl.sv
// ************************************************
// Prefetch controller
// Issues sequential OBI fetches within the slot budget
// ************************************************
`timescale 1ns/10ps

module fetch_prefetch_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                fetch_enable_i,
  input  logic [31:0]         boot_addr_i,
  input  fetch_pkg::obi_rsp_t obi_rsp_i,
  input  logic                fifo_pop_i,
  output fetch_pkg::obi_req_t obi_req_o,
  output logic [31:0]         addr_q_o
);

  logic [31:0]      next_addr_q;
  logic [31:0]      out_addr_q [fetch_pkg::FIFO_DEPTH];
  fetch_pkg::ptr_t  out_wr_ptr_q;
  fetch_pkg::ptr_t  out_rd_ptr_q;
  fetch_pkg::slot_t slot_cnt_q;
  logic             req_hold_q;
  logic             req;
  logic             grant;

  // Once raised, req stays up until the address phase
  assign req   = req_hold_q |
                 (fetch_enable_i & (slot_cnt_q < fetch_pkg::SLOT_MAX));
  assign grant = req & obi_rsp_i.gnt;

  assign obi_req_o.req  = req;
  assign obi_req_o.addr = next_addr_q;

  // Address of the oldest fetch still waiting for rvalid
  assign addr_q_o = out_addr_q[out_rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      next_addr_q  <= boot_addr_i;
      out_wr_ptr_q <= '0;
      out_rd_ptr_q <= '0;
      slot_cnt_q   <= '0;
      req_hold_q   <= 1'b0;
    end else begin
      req_hold_q <= req & ~obi_rsp_i.gnt;
      if (grant) begin
        next_addr_q  <= next_addr_q + 32'd4;
        out_wr_ptr_q <= out_wr_ptr_q + fetch_pkg::ptr_t'(1);
      end
      if (obi_rsp_i.rvalid) begin
        out_rd_ptr_q <= out_rd_ptr_q + fetch_pkg::ptr_t'(1);
      end
      // Slot reserved at grant, released when the entry leaves the FIFO
      case ({grant, fifo_pop_i})
        2'b10:   slot_cnt_q <= slot_cnt_q + fetch_pkg::slot_t'(1);
        2'b01:   slot_cnt_q <= slot_cnt_q - fetch_pkg::slot_t'(1);
        default: slot_cnt_q <= slot_cnt_q;
      endcase
    end
  end

  // In-order queue of granted addresses
  always_ff @(posedge clk_i) begin
    if (grant) begin
      out_addr_q[out_wr_ptr_q] <= next_addr_q;
    end
  end

endmodule

//--- logic/fetch_prefetch_fifo.sv
// ************************************************
// Prefetch FIFO
// Buffers fetched words with their PCs for decode
// ************************************************
`timescale 1ns/10ps

module fetch_prefetch_fifo (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  fetch_pkg::obi_rsp_t     obi_rsp_i,
  input  logic [31:0]             addr_q_i,
  input  logic                    ready_i,
  output logic                    valid_o,
  output fetch_pkg::fetch_entry_t entry_o,
  output logic                    pop_o
);

  fetch_pkg::fetch_entry_t mem_q [fetch_pkg::FIFO_DEPTH];
  fetch_pkg::ptr_t         wr_ptr_q;
  fetch_pkg::ptr_t         rd_ptr_q;
  fetch_pkg::slot_t        cnt_q;
  logic                    push;

  // The controller reserves an entry at grant for every rvalid
  assign push = obi_rsp_i.rvalid;

  assign valid_o = (cnt_q != '0);
  assign pop_o   = valid_o & ready_i;
  assign entry_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + fetch_pkg::ptr_t'(1);
      end
      if (pop_o) begin
        rd_ptr_q <= rd_ptr_q + fetch_pkg::ptr_t'(1);
      end
      case ({push, pop_o})
        2'b10:   cnt_q <= cnt_q + fetch_pkg::slot_t'(1);
        2'b01:   cnt_q <= cnt_q - fetch_pkg::slot_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q].pc    <= addr_q_i;
      mem_q[wr_ptr_q].instr <= obi_rsp_i.rdata;
    end
  end

endmodule

//--- logic/fetch_insn_log.sv
// ************************************************
// Instruction log
// Counts delivered and illegal instructions
// ************************************************
`timescale 1ns/10ps

module fetch_insn_log (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  input  logic                    ready_i,
  input  fetch_pkg::fetch_entry_t entry_i,
  output logic [fetch_pkg::CNT_W-1:0] insn_cnt_o,
  output logic [fetch_pkg::CNT_W-1:0] illegal_cnt_o
);

  fetch_pkg::instr_u insn;
  logic              xfer;
  logic              illegal;

  assign xfer = valid_i & ready_i;
  assign insn = entry_i.instr;

  always_comb begin
    illegal = 1'b0;
    case (insn.r.opcode)
      fetch_pkg::OPC_LUI, fetch_pkg::OPC_AUIPC, fetch_pkg::OPC_JAL,
      fetch_pkg::OPC_JALR, fetch_pkg::OPC_BRANCH, fetch_pkg::OPC_LOAD,
      fetch_pkg::OPC_STORE, fetch_pkg::OPC_FENCE, fetch_pkg::OPC_SYSTEM: begin
        illegal = 1'b0;
      end
      fetch_pkg::OPC_OP: begin
        // Only the base and the SUB/SRA encodings
        illegal = (insn.r.funct7 != 7'b0000000) && (insn.r.funct7 != 7'b0100000);
      end
      fetch_pkg::OPC_OPIMM: begin
        // Shifts keep the upper immediate bits as a function code
        if ((insn.i.funct3 == 3'b001) || (insn.i.funct3 == 3'b101)) begin
          illegal = (insn.i.imm12[11:5] != 7'b0000000) &&
                    (insn.i.imm12[11:5] != 7'b0100000);
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      insn_cnt_o    <= '0;
      illegal_cnt_o <= '0;
    end else if (xfer) begin
      insn_cnt_o <= insn_cnt_o + fetch_pkg::cnt_t'(1);
      if (illegal) begin
        illegal_cnt_o <= illegal_cnt_o + fetch_pkg::cnt_t'(1);
      end
    end
  end

endmodule

//--- logic/fetch_wrapper.sv
// ************************************************
// Fetch wrapper
// Flat OBI and decode ports around the fetch blocks
// ************************************************
`timescale 1ns/10ps

module fetch_wrapper (
  // Clock, reset and control
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        fetch_enable_i,
  input  logic [31:0]                 boot_addr_i,

  // Instruction memory interface
  output logic                        instr_req_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  output logic [31:0]                 instr_addr_o,
  input  logic [31:0]                 instr_rdata_i,

  // Decode side
  output logic                        instr_valid_o,
  input  logic                        instr_ready_i,
  output logic [31:0]                 instr_o,
  output logic [31:0]                 pc_o,

  // Counters
  output logic [fetch_pkg::CNT_W-1:0] insn_cnt_o,
  output logic [fetch_pkg::CNT_W-1:0] illegal_cnt_o
);

  fetch_pkg::obi_req_t     obi_req;
  fetch_pkg::obi_rsp_t     obi_rsp;
  fetch_pkg::fetch_entry_t entry;
  logic [31:0]             addr_q;
  logic                    fifo_pop;

  fetch_prefetch_ctrl ctrl_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .obi_rsp_i      ( obi_rsp        ),
    .fifo_pop_i     ( fifo_pop       ),
    .obi_req_o      ( obi_req        ),
    .addr_q_o       ( addr_q         )
  );

  fetch_prefetch_fifo fifo_i (
    .clk_i     ( clk_i         ),
    .rst_n_i   ( rst_n_i       ),
    .obi_rsp_i ( obi_rsp       ),
    .addr_q_i  ( addr_q        ),
    .ready_i   ( instr_ready_i ),
    .valid_o   ( instr_valid_o ),
    .entry_o   ( entry         ),
    .pop_o     ( fifo_pop      )
  );

  fetch_insn_log log_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .valid_i       ( instr_valid_o ),
    .ready_i       ( instr_ready_i ),
    .entry_i       ( entry         ),
    .insn_cnt_o    ( insn_cnt_o    ),
    .illegal_cnt_o ( illegal_cnt_o )
  );

  // Structs to flat ports
  assign instr_req_o    = obi_req.req;
  assign instr_addr_o   = obi_req.addr;
  assign obi_rsp.gnt    = instr_gnt_i;
  assign obi_rsp.rvalid = instr_rvalid_i;
  assign obi_rsp.rdata  = instr_rdata_i;

  assign instr_o = entry.instr;
  assign pc_o    = entry.pc;

endmodule

//--- bench/fetch_props.sv
// ************************************************
// Fetch properties
// OBI handshake and buffering limit checks
// ************************************************
`timescale 1ns/10ps

module fetch_props (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        req_i,
  input logic [31:0] addr_i,
  input logic        gnt_i,
  input logic        rvalid_i,
  input logic        valid_i,
  input logic        ready_i
);

  int outstanding;
  int in_use;

  // Grants still waiting for rvalid, and grants not yet taken by decode
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding <= 0;
      in_use      <= 0;
    end else begin
      outstanding <= outstanding + int'(req_i & gnt_i) - int'(rvalid_i);
      in_use      <= in_use + int'(req_i & gnt_i) - int'(valid_i & ready_i);
    end
  end

  req_held_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && !gnt_i |=> req_i && $stable(addr_i))
    else $error("request dropped or address changed before grant");

  rvalid_owed_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> outstanding > 0)
    else $error("rvalid without an outstanding request");

  slot_limit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_use <= fetch_pkg::FIFO_DEPTH)
    else $error("outstanding plus buffered fetches exceed the FIFO depth");

endmodule

//--- bench/fetch_tb.sv
// ************************************************
// Fetch testbench
// OBI memory model, random consumer and result checks
// ************************************************
`timescale 1ns/10ps

module fetch_tb;

  localparam int          NUM_WORDS = 24;
  localparam logic [31:0] BOOT_ADDR = 32'h0000_1000;

  logic                        clk_i = 1'b0;
  logic                        rst_n_i;
  logic                        fetch_enable_i;
  logic [31:0]                 boot_addr_i;
  logic                        instr_req_o;
  logic                        instr_gnt_i;
  logic                        instr_rvalid_i;
  logic [31:0]                 instr_addr_o;
  logic [31:0]                 instr_rdata_i;
  logic                        instr_valid_o;
  logic                        instr_ready_i;
  logic [31:0]                 instr_o;
  logic [31:0]                 pc_o;
  logic [fetch_pkg::CNT_W-1:0] insn_cnt_o;
  logic [fetch_pkg::CNT_W-1:0] illegal_cnt_o;

  // Upper word is the legality flag, lower word the instruction
  logic [63:0] td_mem [0:NUM_WORDS];
  int          err_cnt    = 0;
  int          grant_cnt  = 0;
  int          xfer_cnt   = 0;
  logic        hold_ready = 1'b0;
  logic        hold_gnt   = 1'b0;

  always #4 clk_i = ~clk_i;

  fetch_wrapper dut_i (.*);

  bind fetch_wrapper fetch_props props_i (
    .clk_i    ( clk_i          ),
    .rst_n_i  ( rst_n_i        ),
    .req_i    ( instr_req_o    ),
    .addr_i   ( instr_addr_o   ),
    .gnt_i    ( instr_gnt_i    ),
    .rvalid_i ( instr_rvalid_i ),
    .valid_i  ( instr_valid_o  ),
    .ready_i  ( instr_ready_i  )
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("ERROR t=%0t %s", $time, what);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s done with %0d errors", name, err_cnt - errs_before);
  endtask

  // Image words, and an address-derived pattern outside the image
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] offs;
    int          idx;
    offs = addr - BOOT_ADDR;
    idx  = int'(offs >> 2);
    if (addr >= BOOT_ADDR && idx < NUM_WORDS) begin
      return td_mem[idx][31:0];
    end
    return {addr[15:0], ~addr[31:16]};
  endfunction

  // Memory model and consumer sample at negedge and drive 1 ns after posedge
  initial begin : memory_and_consumer
    int          countdown;
    int          last_due;
    int          cyc;
    int          due;
    int          due_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] addr_s;
    logic        req_s;
    logic        grant_s;
    logic        rv_s;
    logic        xfer_s;
    void'($urandom(32'ha362_f491));
    countdown      = 0;
    last_due       = 0;
    cyc            = 0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_ready_i  = 1'b0;
    forever begin
      @(negedge clk_i);
      req_s   = instr_req_o;
      addr_s  = instr_addr_o;
      grant_s = instr_req_o & instr_gnt_i;
      rv_s    = instr_rvalid_i;
      xfer_s  = instr_valid_o & instr_ready_i;
      if (xfer_s) begin
        check_true(xfer_cnt < NUM_WORDS, "transfer past the end of the image");
        check_value("pc_o", pc_o, BOOT_ADDR + 32'(4 * xfer_cnt));
        check_value("instr_o", instr_o, word_at(BOOT_ADDR + 32'(4 * xfer_cnt)));
      end
      if (grant_s) begin
        check_true(addr_s < BOOT_ADDR + 32'(4 * NUM_WORDS),
                   "request past the end of the image was granted");
      end
      @(posedge clk_i);
      cyc++;
      #1;
      if (rv_s) begin
        void'(due_q.pop_front());
        void'(addr_q.pop_front());
      end
      if (grant_s) begin
        grant_cnt++;
        due = cyc + int'($urandom_range(3, 1));
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        due_q.push_back(due);
        addr_q.push_back(addr_s);
        countdown = int'($urandom_range(2, 0));
      end else if (req_s && countdown > 0) begin
        countdown--;
      end
      if (xfer_s) begin
        xfer_cnt++;
      end
      instr_gnt_i    = (countdown == 0) && !hold_gnt;
      instr_rvalid_i = (due_q.size() > 0) && (due_q[0] <= cyc + 1);
      instr_rdata_i  = (due_q.size() > 0) ? word_at(addr_q[0]) : '0;
      instr_ready_i  = !hold_ready && ($urandom_range(3, 0) != 0);
    end
  end

  initial begin : main_sequence
    int          errs;
    int          n;
    int          illegal_sum;
    logic [31:0] last_addr;
    logic [31:0] prev_addr;
    last_addr      = BOOT_ADDR + 32'(4 * (NUM_WORDS - 1));
    prev_addr      = last_addr - 32'd4;
    rst_n_i        = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    $readmemh("bench/fetch_testdata.txt", td_mem);
    repeat (4) @(posedge clk_i);
    #1 rst_n_i = 1'b1;

    errs = err_cnt;
    @(negedge clk_i);
    check_value("instr_req_o", 32'(instr_req_o), 32'd0);
    check_value("instr_valid_o", 32'(instr_valid_o), 32'd0);
    check_value("insn_cnt_o", 32'(insn_cnt_o), 32'd0);
    check_value("illegal_cnt_o", 32'(illegal_cnt_o), 32'd0);
    @(posedge clk_i);
    #1 fetch_enable_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!instr_req_o && n < 20);
    check_true(instr_req_o, "timeout waiting for the first request");
    check_value("instr_addr_o", instr_addr_o, BOOT_ADDR);
    report_test("reset_state", errs);

    errs = err_cnt;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (xfer_cnt < 8 && n < 200);
    check_true(xfer_cnt >= 8, "timeout waiting for eight transfers");
    report_test("sequence", errs);

    errs = err_cnt;
    hold_ready = 1'b1;
    repeat (20) begin
      @(negedge clk_i);
      check_true(grant_cnt - xfer_cnt <= fetch_pkg::FIFO_DEPTH,
                 "more fetches granted than the FIFO can hold while stalled");
    end
    check_value("instr_req_o", 32'(instr_req_o), 32'd0);
    check_value("instr_valid_o", 32'(instr_valid_o), 32'd1);
    hold_ready = 1'b0;
    report_test("back_pressure", errs);

    // Disable while the request for the last word still waits for its grant
    errs = err_cnt;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!(instr_req_o && instr_gnt_i && instr_addr_o == prev_addr) && n < 500);
    check_true(instr_req_o && instr_gnt_i && instr_addr_o == prev_addr,
               "timeout waiting for the grant of the second last word");
    hold_gnt = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!(instr_req_o && instr_addr_o == last_addr) && n < 100);
    check_true(instr_req_o && instr_addr_o == last_addr,
               "timeout waiting for the request of the last word");
    @(posedge clk_i);
    #1 fetch_enable_i = 1'b0;
    @(negedge clk_i);
    check_value("instr_req_o", 32'(instr_req_o), 32'd1);
    check_value("instr_addr_o", instr_addr_o, last_addr);
    hold_gnt = 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!(instr_req_o && instr_gnt_i) && n < 20);
    check_true(instr_req_o && instr_gnt_i, "timeout waiting for the pending grant");
    n = 0;
    do begin
      @(negedge clk_i);
      check_value("instr_req_o", 32'(instr_req_o), 32'd0);
      n++;
    end while ((xfer_cnt < NUM_WORDS || n < 10) && n < 300);
    check_true(xfer_cnt == NUM_WORDS, "timeout waiting for the remaining transfers");
    check_value("grant count", 32'(grant_cnt), 32'(NUM_WORDS));
    report_test("fetch_disable", errs);

    errs = err_cnt;
    illegal_sum = 0;
    for (n = 0; n < NUM_WORDS; n++) begin
      if (td_mem[n][63:32] != 32'd0) begin
        illegal_sum++;
      end
    end
    check_value("data file word count", 32'(NUM_WORDS), td_mem[NUM_WORDS][63:32]);
    check_value("data file illegal count", 32'(illegal_sum), td_mem[NUM_WORDS][31:0]);
    check_value("insn_cnt_o", 32'(insn_cnt_o), td_mem[NUM_WORDS][63:32]);
    check_value("illegal_cnt_o", 32'(illegal_cnt_o), td_mem[NUM_WORDS][31:0]);
    report_test("classification", errs);

    $display("totals: %0d grants, %0d transfers, %0d errors", grant_cnt, xfer_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- bench/fetch_testdata.txt
// Columns: illegal flag (1 = illegal) _ instruction word, one line per word from boot address
// Last line: expected instruction count _ expected illegal count
00000000_00000013 // addi x0,x0,0
00000000_00500093 // addi x1,x0,5
00000000_00208133 // add
00000000_40208133 // sub
00000001_02208133 // OP with funct7 0000001
00000000_00109093 // slli
00000000_4010d093 // srai
00000001_0210d093 // shift right with imm[11:5] 0000001
00000001_8010d093 // shift right with imm[11:5] 1000000
00000000_80000093 // addi with negative immediate
00000000_000012b7 // lui
00000000_00000297 // auipc
00000000_0040006f // jal
00000000_00008067 // jalr
00000000_00208463 // beq
00000000_0000a183 // lw
00000000_0020a023 // sw
00000000_0ff0000f // fence
00000000_00000073 // ecall
00000001_00000000 // all zero word
00000001_ffffffff // all ones word
00000001_0000007b // custom opcode
00000001_fe208133 // OP with funct7 1111111
00000000_0020f133 // and
00000018_00000007 // 24 words, 7 illegal

//--- sources.f
logic/fetch_pkg.sv
logic/fetch_prefetch_ctrl.sv
logic/fetch_prefetch_fifo.sv
logic/fetch_insn_log.sv
logic/fetch_wrapper.sv
bench/fetch_props.sv
bench/fetch_tb.sv

//--- run.sh
#!/bin/sh
# Build the fetch testbench with Verilator, run it and check the result
verilator --binary --timing --assert --top-module fetch_tb -f sources.f -o fetch_sim || exit 1
out=$(./obj_dir/fetch_sim)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && echo "run ok" || { echo "run failed"; exit 1; }
